// ==== logic/micro_pkg.sv ====
// microcode field types, unit, action and condition codes, opcode enum
package micro_pkg;

   typedef logic [3:0]  upc_t;       // micro-program counter
   typedef logic [8:0]  uaddr_t;     // {ncond, opcode, upc}
   typedef logic [23:0] ucontrol_t;  // full control word
   typedef logic [4:0]  unit_t;      // raddr / waddr unit address
   typedef logic [3:0]  action_t;    // {flag update, alu op}
   typedef logic [4:0]  cond_t;      // condition select
   typedef logic [2:0]  reg_idx_t;   // general register index

   // unit addresses
   localparam unit_t unit_none  = 5'd0;
   localparam unit_t unit_rd    = 5'd1;  // ir[11:9]
   localparam unit_t unit_rs    = 5'd2;  // ir[8:6]
   localparam unit_t unit_imm   = 5'd3;  // zero-extended ir[7:0], source only
   localparam unit_t unit_alu   = 5'd4;  // source only
   localparam unit_t unit_lat_a = 5'd5;  // target only
   localparam unit_t unit_lat_b = 5'd6;  // target only

   // action field, bit 3 updates the flags
   localparam int act_upd_bit = 3;
   localparam logic [2:0] alu_pass_b = 3'd0;
   localparam logic [2:0] alu_add    = 3'd1;
   localparam logic [2:0] alu_sub    = 3'd2;
   localparam logic [2:0] alu_and    = 3'd3;
   localparam logic [2:0] alu_or     = 3'd4;
   localparam logic [2:0] alu_xor    = 3'd5;

   // condition codes, anything else keeps ncond
   localparam cond_t cond_always = 5'd0;
   localparam cond_t cond_zero   = 5'd1;
   localparam cond_t cond_nzero  = 5'd2;
   localparam cond_t cond_carry  = 5'd3;

   typedef enum logic [3:0] {
      op_nop   = 4'd0,  op_ldi   = 4'd1,  op_mov  = 4'd2,  op_add = 4'd3,
      op_sub   = 4'd4,  op_and   = 4'd5,  op_or   = 4'd6,  op_xor = 4'd7,
      op_movz  = 4'd8,  op_movnz = 4'd9,  op_movc = 4'd10, op_cmp = 4'd11
   } opcode_e;  // 12..15 run as nop

endpackage

// ==== logic/control_store.sv ====
// micro-rom, case table from micro-address to control word
`timescale 1ns/1ps

module control_store import micro_pkg::*; (
   input  uaddr_t    uaddr,
   output ucontrol_t ucontrol
);

   localparam action_t act_idle = {1'b0, alu_pass_b};  // no flag update

   opcode_e     opc;
   upc_t        step;
   logic        ncond_in;
   logic [2:0]  alu_sel;   // alu op for the three-step group
   cond_t       mov_cond;  // condition for conditional moves

   // pack one control word, reserved bits are always ones
   function automatic ucontrol_t uc_word(input logic    nend_b,
                                         input logic    nwen_b,
                                         input action_t act,
                                         input cond_t   cnd,
                                         input unit_t   wa,
                                         input unit_t   ra);
      return {nend_b, nwen_b, 3'b111, act, cnd, wa, ra};
   endfunction

   assign ncond_in = uaddr[8];
   assign opc      = opcode_e'(uaddr[7:4]);
   assign step     = uaddr[3:0];

   always_comb begin
      case (opc)
         op_sub, op_cmp: alu_sel = alu_sub;  // cmp is sub without write-back
         op_and:         alu_sel = alu_and;
         op_or:          alu_sel = alu_or;
         op_xor:         alu_sel = alu_xor;
         default:        alu_sel = alu_add;
      endcase
      case (opc)
         op_movnz: mov_cond = cond_nzero;
         op_movc:  mov_cond = cond_carry;
         default:  mov_cond = cond_zero;
      endcase
   end

   always_comb begin
      // stray addresses just end the instruction
      ucontrol = uc_word(1'b0, 1'b1, act_idle, cond_always, unit_none, unit_none);
      case (opc)
         op_nop: ;  // single ending step
         op_ldi: if (step == 4'd0)
            ucontrol = uc_word(1'b0, 1'b0, act_idle, cond_always, unit_rd, unit_imm);
         op_mov: if (step == 4'd0)
            ucontrol = uc_word(1'b0, 1'b0, act_idle, cond_always, unit_rd, unit_rs);
         op_add, op_sub, op_and, op_or, op_xor, op_cmp: begin
            case (step)
               4'd0: ucontrol = uc_word(1'b1, 1'b1, act_idle, cond_always,
                                        unit_lat_a, unit_rd);
               4'd1: ucontrol = uc_word(1'b1, 1'b1, act_idle, cond_always,
                                        unit_lat_b, unit_rs);
               4'd2: ucontrol = uc_word(1'b0, opc == op_cmp, {1'b1, alu_sel}, cond_always,
                                        (opc == op_cmp) ? unit_none : unit_rd, unit_alu);
               default: ;
            endcase
         end
         op_movz, op_movnz, op_movc: begin
            if (step == 4'd0)       // latch the condition into ncond
               ucontrol = uc_word(1'b1, 1'b1, act_idle, mov_cond, unit_none, unit_none);
            else if (step == 4'd1 && !ncond_in)  // taken, rd <- rs
               ucontrol = uc_word(1'b0, 1'b0, act_idle, cond_always, unit_rd, unit_rs);
         end
         default: ;
      endcase
   end

endmodule

// ==== logic/microcode_sequencer.sv ====
// micro-program counter, micro-address, control store, fetch indicator, front panel mux
`timescale 1ns/1ps

module microcode_sequencer import micro_pkg::*; (
   input  logic        clk4,
   input  logic        rst_n,
   input  logic        nhalt,
   input  logic [15:0] ir,
   input  logic        ncond,
   input  logic        nfpua0,
   input  logic        nfpuc0,
   input  logic        nfpuc1,
   input  logic        nfpuc2,
   output unit_t       raddr,
   output unit_t       waddr,
   output cond_t       cond,
   output action_t     action,
   output logic        nwen,
   output logic        nend,
   output logic        fpfetch,
   output logic [7:0]  fpd
);

   upc_t      upc;
   uaddr_t    uaddr;
   ucontrol_t uc_rom;    // straight from the rom
   ucontrol_t ucontrol;  // after halt / reset forcing

   ////////////////////////////////////////////////////////////////////
   // micro-program counter
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         upc <= '0;
      end else if (nhalt) begin  // frozen while halted
         if (!nend)
            upc <= '0;           // next instruction
         else
            upc <= upc + 4'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // micro-address and control store
   ////////////////////////////////////////////////////////////////////

   assign uaddr = {ncond, ir[15:12], upc};  // cond bit, opcode, step

   control_store u_cs (
      .uaddr    (uaddr),
      .ucontrol (uc_rom)
   );

   // rom disabled reads as all ones, strobes idle high
   assign ucontrol = (!rst_n || !nhalt) ? '1 : uc_rom;

   assign nend   = ucontrol[23];
   assign nwen   = ucontrol[22];
   assign action = ucontrol[18:15];  // 21..19 reserved
   assign cond   = ucontrol[14:10];
   assign waddr  = ucontrol[9:5];
   assign raddr  = ucontrol[4:0];

   ////////////////////////////////////////////////////////////////////
   // fetch indicator and front panel
   ////////////////////////////////////////////////////////////////////

   assign fpfetch = (upc < 4'd2);  // operand fetch steps

   always_comb begin
      if (!nfpua0)
         fpd = uaddr[7:0];         // opcode and step
      else if (!nfpuc0)
         fpd = ucontrol[7:0];
      else if (!nfpuc1)
         fpd = ucontrol[15:8];
      else if (!nfpuc2)
         fpd = ucontrol[23:16];    // strobes on top
      else
         fpd = 8'hff;              // idle bus
   end

endmodule

// ==== logic/execute_unit.sv ====
// register file, operand latches, source mux, alu and write-back strobes
`timescale 1ns/1ps

module execute_unit import micro_pkg::*; #(
   parameter int data_width = 16
) (
   input  logic                  clk4,
   input  logic                  rst_n,
   input  logic [15:0]           ir,
   input  unit_t                 raddr,
   input  unit_t                 waddr,
   input  action_t               action,
   input  logic                  nwen,
   output logic [data_width-1:0] alu_out,
   output logic                  alu_carry,
   output logic                  flag_upd,
   output reg_idx_t              wb_reg,
   output logic [data_width-1:0] wb_data
);

   logic [data_width-1:0] regs [8];     // general registers
   logic [data_width-1:0] lat_a, lat_b; // operand latches
   logic [data_width-1:0] src_val;      // value on the internal bus
   logic [data_width:0]   alu_wide;     // carry on top
   logic                  alu_valid;
   logic                  reg_we;
   reg_idx_t              rd_idx, rs_idx;

   assign rd_idx = ir[11:9];
   assign rs_idx = ir[8:6];

   ////////////////////////////////////////////////////////////////////
   // source mux
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      case (raddr)
         unit_rd:  src_val = regs[rd_idx];
         unit_rs:  src_val = regs[rs_idx];
         unit_imm: src_val = data_width'(ir[7:0]);  // zero-extended byte
         unit_alu: src_val = alu_out;
         default:  src_val = '0;
      endcase
   end

   ////////////////////////////////////////////////////////////////////
   // alu on the latches
   ////////////////////////////////////////////////////////////////////

   always_comb begin
      alu_valid = 1'b1;
      case (action[2:0])
         alu_pass_b: alu_wide = {1'b0, lat_b};
         alu_add:    alu_wide = {1'b0, lat_a} + {1'b0, lat_b};  // carry out
         alu_sub:    alu_wide = {1'b0, lat_a} - {1'b0, lat_b};  // top bit is borrow
         alu_and:    alu_wide = {1'b0, lat_a & lat_b};
         alu_or:     alu_wide = {1'b0, lat_a | lat_b};
         alu_xor:    alu_wide = {1'b0, lat_a ^ lat_b};
         default: begin              // idle word while halted
            alu_wide  = {1'b0, lat_b};
            alu_valid = 1'b0;
         end
      endcase
   end

   assign alu_out   = alu_wide[data_width-1:0];
   assign alu_carry = alu_wide[data_width];
   assign flag_upd  = action[act_upd_bit] & alu_valid;

   ////////////////////////////////////////////////////////////////////
   // write-back
   ////////////////////////////////////////////////////////////////////

   assign wb_reg  = (waddr == unit_rs) ? rs_idx : rd_idx;
   assign wb_data = src_val;
   assign reg_we  = !nwen && (waddr == unit_rd || waddr == unit_rs);

   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++)
            regs[i] <= '0;
         lat_a <= '0;
         lat_b <= '0;
      end else begin
         if (reg_we)
            regs[wb_reg] <= src_val;
         if (waddr == unit_lat_a) lat_a <= src_val;  // latches ignore nwen
         if (waddr == unit_lat_b) lat_b <= src_val;
      end
   end

endmodule

// ==== logic/result_unit.sv ====
// flag register, condition evaluation, registered active-low condition bit
`timescale 1ns/1ps

module result_unit import micro_pkg::*; #(
   parameter int data_width = 16
) (
   input  logic                  clk4,
   input  logic                  rst_n,
   input  logic [data_width-1:0] alu_out,
   input  logic                  alu_carry,
   input  logic                  flag_upd,
   input  cond_t                 cond,
   output logic                  ncond,
   output logic                  flag_z,
   output logic                  flag_c
);

   // flags, only on update steps
   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         flag_z <= 1'b0;
         flag_c <= 1'b0;
      end else if (flag_upd) begin
         flag_z <= (alu_out == '0);
         flag_c <= alu_carry;  // alu clears it for logic ops
      end
   end

   // condition bit, evaluated on the flags before this step's update
   always_ff @(posedge clk4) begin
      if (!rst_n) begin
         ncond <= 1'b1;
      end else begin
         case (cond)
            cond_always: ncond <= 1'b0;
            cond_zero:   ncond <= ~flag_z;
            cond_nzero:  ncond <= flag_z;
            cond_carry:  ncond <= ~flag_c;
            default:     ncond <= ncond;  // idle word keeps it across halt
         endcase
      end
   end

endmodule

// ==== logic/micro_core.sv ====
// top level, sequencer with execute and result units
`timescale 1ns/1ps

module micro_core import micro_pkg::*; #(
   parameter int data_width = 16
) (
   input  logic                  clk4,
   input  logic                  rst_n,
   input  logic                  nhalt,
   input  logic [15:0]           ir,
   input  logic                  nfpua0,
   input  logic                  nfpuc0,
   input  logic                  nfpuc1,
   input  logic                  nfpuc2,
   output logic                  nend,
   output logic                  nwen,
   output reg_idx_t              wb_reg,
   output logic [data_width-1:0] wb_data,
   output logic                  fpfetch,
   output logic [7:0]            fpd,
   output logic                  flag_z,
   output logic                  flag_c
);

   unit_t                 raddr, waddr;
   cond_t                 cond;
   action_t               action;
   logic                  ncond;
   logic [data_width-1:0] alu_out;
   logic                  alu_carry;
   logic                  flag_upd;

   microcode_sequencer u_seq (
      .clk4, .rst_n, .nhalt, .ir, .ncond,
      .nfpua0, .nfpuc0, .nfpuc1, .nfpuc2,
      .raddr, .waddr, .cond, .action,
      .nwen, .nend, .fpfetch, .fpd
   );

   execute_unit #(.data_width(data_width)) u_exe (
      .clk4, .rst_n, .ir, .raddr, .waddr, .action, .nwen,
      .alu_out, .alu_carry, .flag_upd, .wb_reg, .wb_data
   );

   result_unit #(.data_width(data_width)) u_res (
      .clk4, .rst_n, .alu_out, .alu_carry, .flag_upd, .cond,
      .ncond, .flag_z, .flag_c
   );

endmodule

// ==== bench/micro_core_tb.sv ====
// micro_core testbench with instruction table, write monitor, halt and front panel checks
`timescale 1ns/1ps

module micro_core_tb import micro_pkg::*; ();

   typedef struct packed {
      logic [15:0] ir;
      logic        wr;     // write expected
      logic [2:0]  rg;
      logic [15:0] data;
      logic        z;
      logic        c;
      logic [3:0]  last;   // step that ends
   } entry_t;

   logic        clk4 = 1'b0;
   logic        rst_n, nhalt, nfpua0, nfpuc0, nfpuc1, nfpuc2;
   logic [15:0] ir;
   logic        nend, nwen, fpfetch, flag_z, flag_c;
   reg_idx_t    wb_reg;
   logic [15:0] wb_data;
   logic [7:0]  fpd;

   entry_t      tbl [0:31];
   int          n_entries = 0;
   int          halt_idx = -1;  // entry that gets frozen mid-way
   int          errors = 0;
   logic [15:0] rm [0:7];       // expected register contents
   logic        zf, cf;         // expected flags
   logic [7:0]  imm_a, imm_b;
   int unsigned seed_ret;

   micro_core #(.data_width(16)) UUT (
      .clk4, .rst_n, .nhalt, .ir, .nfpua0, .nfpuc0, .nfpuc1, .nfpuc2,
      .nend, .nwen, .wb_reg, .wb_data, .fpfetch, .fpd, .flag_z, .flag_c
   );

   always #10 clk4 = ~clk4;  // 20 ns period

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Fail %s: got %h expected %h", name, got, exp);
      end
   endtask

   ////////////////////////////////////////////////////////////////////
   // table building with expected values from the flag and move rules
   ////////////////////////////////////////////////////////////////////

   task automatic add_entry(input logic [15:0] iw, input logic wr, input reg_idx_t rg,
                            input logic [15:0] data, input logic [3:0] last);
      tbl[n_entries] = {iw, wr, rg, data, zf, cf, last};
      n_entries++;
   endtask

   task automatic add_ldi(input reg_idx_t rd, input logic [7:0] imm);
      rm[rd] = {8'h00, imm};  // zero-extended
      add_entry({op_ldi, rd, 1'b0, imm}, 1'b1, rd, rm[rd], 4'd0);
   endtask

   task automatic add_alu(input logic [3:0] op, input reg_idx_t rd, input reg_idx_t rs);
      logic [15:0] res;
      cf  = 1'b0;           // logic ops clear carry
      case (op)
         op_add: begin
            res = rm[rd] + rm[rs];
            cf  = res < rm[rd];  // sum wrapped so carry out
         end
         op_sub, op_cmp: begin
            res = rm[rd] - rm[rs];
            cf  = rm[rd] < rm[rs];  // borrow
         end
         op_and:  res = rm[rd] & rm[rs];
         op_or:   res = rm[rd] | rm[rs];
         default: res = rm[rd] ^ rm[rs];
      endcase
      zf = (res == 16'h0000);
      if (op != op_cmp)
         rm[rd] = res;
      add_entry({op, rd, rs, 6'd0}, op != op_cmp, rd, res, 4'd2);
   endtask

   task automatic add_move(input logic [3:0] op, input reg_idx_t rd, input reg_idx_t rs);
      logic take;
      case (op)
         op_movz:  take = zf;
         op_movnz: take = !zf;
         op_movc:  take = cf;
         default:  take = 1'b1;  // plain mov
      endcase
      if (take)
         rm[rd] = rm[rs];
      add_entry({op, rd, rs, 6'd0}, take, rd, rm[rs], (op == op_mov) ? 4'd0 : 4'd1);
   endtask

   ////////////////////////////////////////////////////////////////////
   // running one instruction
   ////////////////////////////////////////////////////////////////////

   // freeze for 4 cycles with the panel on opcode and frozen step
   task automatic hold_halted(input logic [3:0] op, input logic [3:0] step,
                              input logic z, input logic c);
      nhalt  = 1'b0;
      nfpua0 = 1'b0;
      repeat (4) begin
         @(negedge clk4);
         check("nend", nend, 1'b1);
         check("nwen", nwen, 1'b1);
         check("fpd", fpd, {op, step});
         check("flag_z", flag_z, z);  // flags frozen with the rest
         check("flag_c", flag_c, c);
         @(posedge clk4);
         #2;
      end
      nhalt  = 1'b1;
      nfpua0 = 1'b1;
   endtask

   task automatic run_entry(input int idx, input int hold_step);
      entry_t   e;
      int       step;
      logic     done, written;
      logic     prev_z, prev_c;
      reg_idx_t rec_reg;
      logic [15:0] rec_data;
      e        = tbl[idx];
      prev_z   = (idx > 0) ? tbl[idx-1].z : 1'b0;  // flags left by the previous entry
      prev_c   = (idx > 0) ? tbl[idx-1].c : 1'b0;
      step     = 0;
      done     = 1'b0;
      written  = 1'b0;
      rec_reg  = '0;
      rec_data = '0;
      ir       = e.ir;  // held until the ending edge
      while (!done) begin
         if (step == hold_step)
            hold_halted(e.ir[15:12], 4'(step), prev_z, prev_c);
         @(negedge clk4);
         if (!nwen) begin  // write monitor
            written  = 1'b1;
            rec_reg  = wb_reg;
            rec_data = wb_data;
         end
         check("fpfetch", fpfetch, step < 2);
         if (!nend) begin
            check("nend step", step, e.last);
            done = 1'b1;
         end else if (step >= 8) begin
            errors++;
            $display("entry %0d: timed out waiting for the end of the instruction", idx);
            done = 1'b1;
         end
         @(posedge clk4);
         #2;
         step++;
      end
      check("write", written, e.wr);
      if (e.wr) begin
         check("wb_reg", rec_reg, e.rg);
         check("wb_data", rec_data, e.data);
      end
      check("flag_z", flag_z, e.z);  // flags settle at the ending edge
      check("flag_c", flag_c, e.c);
   endtask

   ////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////

   initial begin
      rst_n  = 1'b0;
      nhalt  = 1'b1;
      ir     = 16'h0000;
      nfpua0 = 1'b1;
      nfpuc0 = 1'b1;
      nfpuc1 = 1'b1;
      nfpuc2 = 1'b1;
      seed_ret = $urandom(32'h17c11b24);
      imm_a = 8'($urandom % 256);
      imm_b = 8'(1 + $urandom % 255);  // nonzero so zero minus b borrows
      for (int i = 0; i < 8; i++)
         rm[i] = 16'h0000;
      zf = 1'b0;
      cf = 1'b0;

      add_entry({op_nop, 12'h000}, 1'b0, 3'd0, 16'h0000, 4'd0);
      add_ldi(3'd1, imm_a);
      add_ldi(3'd2, imm_b);
      add_move(op_mov, 3'd3, 3'd1);
      add_alu(op_add, 3'd1, 3'd2);
      add_alu(op_sub, 3'd4, 3'd2);    // zero minus b borrows
      add_alu(op_add, 3'd4, 3'd2);    // wraps to zero with carry out
      add_move(op_movz, 3'd5, 3'd1);
      add_move(op_movnz, 3'd6, 3'd1);
      add_move(op_movc, 3'd6, 3'd2);
      add_alu(op_xor, 3'd6, 3'd2);    // equal values give zero
      add_move(op_movc, 3'd7, 3'd1);  // carry cleared so no write
      add_alu(op_and, 3'd1, 3'd2);
      add_alu(op_or, 3'd5, 3'd2);
      add_alu(op_cmp, 3'd2, 3'd1);
      add_alu(op_cmp, 3'd1, 3'd2);
      add_move(op_movnz, 3'd7, 3'd2);
      halt_idx = n_entries;
      add_alu(op_add, 3'd3, 3'd2);    // halted at step 1

      repeat (4) @(posedge clk4);
      #2;
      rst_n = 1'b1;

      for (int i = 0; i < n_entries; i++)
         run_entry(i, (i == halt_idx) ? 1 : -1);

      // idle panel then top control byte on a nop
      ir = {op_nop, 12'h000};
      @(negedge clk4);
      check("fpd", fpd, 8'hff);
      @(posedge clk4);
      #2;
      nfpuc2 = 1'b0;
      @(negedge clk4);
      check("fpd[7:6]", fpd[7:6], 2'b01);
      @(posedge clk4);
      #2;
      nfpuc2 = 1'b1;

      $display("entries run: %0d, errors: %0d", n_entries, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== micro_seq.f ====
logic/micro_pkg.sv
logic/control_store.sv
logic/microcode_sequencer.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/micro_core.sv
bench/micro_core_tb.sv

// ==== Bender.yml ====
package:
  name: micro_seq

sources:
  - logic/micro_pkg.sv
  - logic/control_store.sv
  - logic/microcode_sequencer.sv
  - logic/execute_unit.sv
  - logic/result_unit.sv
  - logic/micro_core.sv
  - target: test
    files:
      - bench/micro_core_tb.sv
